//--- logic/pfb_pkg.sv
/*
  Prefetch buffer package
  Geometry, payload types, request and result codes, refill timeout
*/
package pfb_pkg;

  // ------------------------------
  // Geometry
  // ------------------------------
  localparam int WORD_BITS     = 32;
  localparam int ADDR_BITS     = 32;
  localparam int LINE_BITS     = 128;
  localparam int NUM_SETS      = 8;
  localparam int IDX_BITS      = 3;
  // Word offset sits at address bits 3 and 2
  localparam int OFF_BITS      = 2;
  localparam int BYTE_BITS     = 2;
  localparam int LINE_OFF_BITS = BYTE_BITS + OFF_BITS;
  localparam int TAG_BITS      = ADDR_BITS - LINE_OFF_BITS - IDX_BITS;

  // ------------------------------
  // Refill timing
  // ------------------------------
  localparam int REFILL_TIMEOUT = 16;
  localparam int TIMER_BITS     = $clog2(REFILL_TIMEOUT + 1);

  // Payloads
  typedef logic [WORD_BITS-1:0] word_t;
  // Word k occupies bits 32k upward
  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [TAG_BITS-1:0]  tag_t;
  typedef logic [ADDR_BITS-1:0] addr_t;

  // Request kinds
  typedef enum logic {
    REQ_READ     = 1'b0,
    REQ_PREFETCH = 1'b1
  } req_type_t;

  // Result code sent with every response
  typedef enum logic [1:0] {
    FOUND_MISS   = 2'd0,
    FOUND_HIT    = 2'd1,
    FOUND_FILLED = 2'd2,
    FOUND_ABORT  = 2'd3
  } found_t;

endpackage

//--- logic/pfb_regfile.sv
/*
  Register file with one combinational read port and one write port
  Payload type is set per instance, used for tags and for lines
*/
`timescale 1ns/10ps

module pfb_regfile #(
  parameter type entry_t = logic,
  parameter int  depth   = 8
) (
  input  logic                     clk,
  input  logic                     write_en,
  input  logic [$clog2(depth)-1:0] write_idx,
  input  logic [$clog2(depth)-1:0] read_idx,
  input  entry_t                   write_data,
  output entry_t                   read_data
);

  entry_t mem [depth];

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_idx] <= write_data;
    end
  end

  assign read_data = mem[read_idx];

  // Index comes from the request register in the controller
  a_write_idx_known: assert property (
    @(posedge clk) write_en |-> !$isunknown(write_idx)
  );

endmodule

//--- logic/pfb_tag_array.sv
/*
  Tag array for two ways with valid and LRU state per set
  Detects hits and records the way used by the rest of the transaction
*/
`timescale 1ns/10ps

module pfb_tag_array (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [pfb_pkg::IDX_BITS-1:0] req_idx,
  input  pfb_pkg::tag_t                req_tag,
  input  logic                         way_record_en,
  input  logic                         fill_en,
  input  logic                         lru_touch,
  output logic                         hit,
  output logic                         hit_way,
  output logic                         sel_way
);

  pfb_pkg::tag_t                way_tag [2];
  logic [1:0]                   way_hit;
  logic [pfb_pkg::NUM_SETS-1:0] valid_q [2];
  // One bit per set naming the least recently used way
  logic [pfb_pkg::NUM_SETS-1:0] lru_q;
  logic                         victim_way;

  // ------------------------------
  // Tag storage and compare
  // ------------------------------
  for (genvar w = 0; w < 2; w++) begin : g_way
    pfb_regfile #(
      .entry_t (pfb_pkg::tag_t),
      .depth   (pfb_pkg::NUM_SETS)
    ) i_tags (
      .clk        (clk),
      .write_en   (fill_en && (sel_way == 1'(w))),
      .write_idx  (req_idx),
      .read_idx   (req_idx),
      .write_data (req_tag),
      .read_data  (way_tag[w])
    );

    assign way_hit[w] = valid_q[w][req_idx] && (way_tag[w] == req_tag);
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  // Hit way, else a free way with way 0 first, else the LRU way
  always_comb begin
    if (hit) begin
      victim_way = hit_way;
    end else if (!valid_q[0][req_idx]) begin
      victim_way = 1'b0;
    end else if (!valid_q[1][req_idx]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[req_idx];
    end
  end

  // ------------------------------
  // Way record, valid and LRU
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_way    <= 1'b0;
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      lru_q      <= '0;
    end else begin
      if (way_record_en) begin
        sel_way <= victim_way;
      end
      if (fill_en) begin
        valid_q[sel_way][req_idx] <= 1'b1;
      end
      // Recorded way just got used, so the other one becomes LRU
      if (lru_touch) begin
        lru_q[req_idx] <= ~sel_way;
      end
    end
  end

  a_one_way_hits: assert property (
    @(posedge clk) disable iff (reset) way_record_en |-> !(&way_hit)
  );

endmodule

//--- logic/pfb_data_path.sv
/*
  Data lines for two ways, refill write and response word register
*/
`timescale 1ns/10ps

module pfb_data_path (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [pfb_pkg::IDX_BITS-1:0] req_idx,
  input  logic [pfb_pkg::OFF_BITS-1:0] req_off,
  input  logic                         sel_way,
  input  logic                         fill_en,
  input  logic                         resp_load,
  input  logic                         resp_clear,
  input  pfb_pkg::line_t               memresp_data,
  output pfb_pkg::word_t               resp_data
);

  pfb_pkg::line_t way_line [2];
  pfb_pkg::line_t fill_line;
  pfb_pkg::line_t sel_line;

  // ------------------------------
  // Line storage
  // ------------------------------
  for (genvar w = 0; w < 2; w++) begin : g_way
    pfb_regfile #(
      .entry_t (pfb_pkg::line_t),
      .depth   (pfb_pkg::NUM_SETS)
    ) i_lines (
      .clk        (clk),
      .write_en   (fill_en && (sel_way == 1'(w))),
      .write_idx  (req_idx),
      .read_idx   (req_idx),
      .write_data (fill_line),
      .read_data  (way_line[w])
    );
  end

  // Memory line staged for the update cycle after the response
  always_ff @(posedge clk) begin
    fill_line <= memresp_data;
  end

  assign sel_line = way_line[sel_way];

  // ------------------------------
  // Response word
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_data <= '0;
    end else if (resp_clear) begin
      resp_data <= '0;
    end else if (resp_load) begin
      resp_data <= sel_line[req_off * pfb_pkg::WORD_BITS +: pfb_pkg::WORD_BITS];
    end
  end

endmodule

//--- logic/pfb_refill_timer.sv
/*
  Refill timer, counts down the wait for a memory response
*/
`timescale 1ns/10ps

module pfb_refill_timer (
  input  logic clk,
  input  logic reset,
  input  logic timer_start,
  input  logic timer_clear,
  output logic timeout
);

  logic [pfb_pkg::TIMER_BITS-1:0] count_q;
  logic                           running_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (timer_start) begin
      count_q   <= pfb_pkg::TIMER_BITS'(pfb_pkg::REFILL_TIMEOUT);
      running_q <= 1'b1;
    end else if (timer_clear) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (running_q && (count_q != '0)) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Expired: still armed and nothing left to count
  assign timeout = running_q && (count_q == '0);

  // Controller clears the timer on every exit from the refill wait
  a_start_idle: assert property (
    @(posedge clk) disable iff (reset) timer_start |-> !running_q
  );

endmodule

//--- logic/pfb_ctrl.sv
/*
  Prefetch buffer controller
  Request FSM, request registers, result code and array strobes
*/
`timescale 1ns/10ps

module pfb_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  pfb_pkg::req_type_t           req_type,
  input  pfb_pkg::addr_t               req_addr,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output pfb_pkg::found_t              resp_found,
  output logic                         memreq_val,
  input  logic                         memreq_rdy,
  output pfb_pkg::addr_t               memreq_addr,
  input  logic                         memresp_val,
  output logic                         memresp_rdy,
  input  logic                         insecure,
  input  logic                         hit,
  input  logic                         timeout,
  output logic [pfb_pkg::IDX_BITS-1:0] req_idx,
  output pfb_pkg::tag_t                req_tag,
  output logic [pfb_pkg::OFF_BITS-1:0] req_off,
  output logic                         way_record_en,
  output logic                         fill_en,
  output logic                         lru_touch,
  output logic                         resp_load,
  output logic                         resp_clear,
  output logic                         timer_start,
  output logic                         timer_clear
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_TAG_CHECK,
    ST_READ_ACCESS,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_REFILL_UPDATE,
    ST_WAIT
  } state_t;

  state_t             state_q;
  state_t             state_next;
  pfb_pkg::req_type_t req_type_q;
  pfb_pkg::addr_t     req_addr_q;
  logic               is_read;
  logic               refill_abort;

  assign is_read      = (req_type_q == pfb_pkg::REQ_READ);
  assign refill_abort = insecure || (timeout && !memresp_val);

  // ------------------------------
  // Request registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      req_type_q <= req_type;
      req_addr_q <= req_addr;
    end
  end

  assign req_off     = req_addr_q[pfb_pkg::BYTE_BITS +: pfb_pkg::OFF_BITS];
  assign req_idx     = req_addr_q[pfb_pkg::LINE_OFF_BITS +: pfb_pkg::IDX_BITS];
  assign req_tag     = req_addr_q[pfb_pkg::ADDR_BITS-1 -: pfb_pkg::TAG_BITS];
  assign memreq_addr = {req_addr_q[pfb_pkg::ADDR_BITS-1:pfb_pkg::LINE_OFF_BITS],
                        {pfb_pkg::LINE_OFF_BITS{1'b0}}};

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_next = state_q;
    unique case (state_q)
      ST_IDLE:          if (req_val) state_next = ST_TAG_CHECK;
      ST_TAG_CHECK: begin
        if (hit) begin
          state_next = is_read ? ST_READ_ACCESS : ST_WAIT;
        end else begin
          state_next = is_read ? ST_WAIT : ST_REFILL_REQ;
        end
      end
      ST_READ_ACCESS:   state_next = ST_WAIT;
      ST_REFILL_REQ:    if (memreq_rdy) state_next = ST_REFILL_WAIT;
      ST_REFILL_WAIT: begin
        if (refill_abort) begin
          state_next = ST_WAIT;
        end else if (memresp_val) begin
          state_next = ST_REFILL_UPDATE;
        end
      end
      ST_REFILL_UPDATE: state_next = ST_WAIT;
      ST_WAIT:          if (resp_rdy) state_next = ST_IDLE;
      default:          state_next = ST_IDLE;
    endcase
  end

  // State and result code
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= ST_IDLE;
      resp_found <= pfb_pkg::FOUND_MISS;
    end else begin
      state_q <= state_next;
      if (state_q == ST_TAG_CHECK) begin
        resp_found <= hit ? pfb_pkg::FOUND_HIT : pfb_pkg::FOUND_MISS;
      end else if (state_q == ST_REFILL_WAIT) begin
        if (refill_abort) begin
          resp_found <= pfb_pkg::FOUND_ABORT;
        end else if (memresp_val) begin
          resp_found <= pfb_pkg::FOUND_FILLED;
        end
      end
    end
  end

  // ------------------------------
  // Strobes and handshakes
  // ------------------------------
  assign req_rdy       = (state_q == ST_IDLE);
  assign resp_val      = (state_q == ST_WAIT);
  assign memreq_val    = (state_q == ST_REFILL_REQ);
  assign memresp_rdy   = (state_q == ST_REFILL_WAIT);
  assign way_record_en = (state_q == ST_TAG_CHECK);
  // Everything but a read hit answers with zero data
  assign resp_clear    = (state_q == ST_TAG_CHECK);
  assign resp_load     = (state_q == ST_READ_ACCESS);
  assign fill_en       = (state_q == ST_REFILL_UPDATE);
  // Read hits and fresh fills both count as a use of the way
  assign lru_touch     = (state_q == ST_READ_ACCESS) || (state_q == ST_REFILL_UPDATE);
  assign timer_start   = (state_q == ST_REFILL_REQ) && memreq_rdy;
  assign timer_clear   = (state_q == ST_REFILL_WAIT) && (refill_abort || memresp_val);

  a_found_stable: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_found)
  );

  a_inputs_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown({req_val, resp_rdy, memreq_rdy, memresp_val, insecure})
  );

endmodule

//--- logic/prefetch_buffer.sv
/*
  Two-way set-associative prefetch buffer, top level
  Word reads and line prefetches with refill from memory
*/
`timescale 1ns/10ps

module prefetch_buffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               insecure,
  input  logic               req_val,
  output logic               req_rdy,
  input  pfb_pkg::req_type_t req_type,
  input  pfb_pkg::addr_t     req_addr,
  output logic               resp_val,
  input  logic               resp_rdy,
  output pfb_pkg::found_t    resp_found,
  output pfb_pkg::word_t     resp_data,
  output logic               memreq_val,
  input  logic               memreq_rdy,
  output pfb_pkg::addr_t     memreq_addr,
  input  logic               memresp_val,
  output logic               memresp_rdy,
  input  pfb_pkg::line_t     memresp_data
);

  logic [pfb_pkg::IDX_BITS-1:0] req_idx;
  pfb_pkg::tag_t                req_tag;
  logic [pfb_pkg::OFF_BITS-1:0] req_off;
  logic                         hit;
  logic                         sel_way;
  logic                         way_record_en;
  logic                         fill_en;
  logic                         lru_touch;
  logic                         resp_load;
  logic                         resp_clear;
  logic                         timer_start;
  logic                         timer_clear;
  logic                         timeout;

  pfb_ctrl i_ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_val       (req_val),
    .req_rdy       (req_rdy),
    .req_type      (req_type),
    .req_addr      (req_addr),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .resp_found    (resp_found),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq_addr   (memreq_addr),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .insecure      (insecure),
    .hit           (hit),
    .timeout       (timeout),
    .req_idx       (req_idx),
    .req_tag       (req_tag),
    .req_off       (req_off),
    .way_record_en (way_record_en),
    .fill_en       (fill_en),
    .lru_touch     (lru_touch),
    .resp_load     (resp_load),
    .resp_clear    (resp_clear),
    .timer_start   (timer_start),
    .timer_clear   (timer_clear)
  );

  pfb_refill_timer i_refill_timer (
    .clk         (clk),
    .reset       (reset),
    .timer_start (timer_start),
    .timer_clear (timer_clear),
    .timeout     (timeout)
  );

  // The hit way reaches the data path through the recorded sel_way
  pfb_tag_array i_tag_array (
    .clk           (clk),
    .reset         (reset),
    .req_idx       (req_idx),
    .req_tag       (req_tag),
    .way_record_en (way_record_en),
    .fill_en       (fill_en),
    .lru_touch     (lru_touch),
    .hit           (hit),
    .hit_way       (),
    .sel_way       (sel_way)
  );

  pfb_data_path i_data_path (
    .clk          (clk),
    .reset        (reset),
    .req_idx      (req_idx),
    .req_off      (req_off),
    .sel_way      (sel_way),
    .fill_en      (fill_en),
    .resp_load    (resp_load),
    .resp_clear   (resp_clear),
    .memresp_data (memresp_data),
    .resp_data    (resp_data)
  );

endmodule

//--- tb/tb_mem_model.sv
/*
  Behavioral memory for the prefetch buffer testbench
  Answers line requests after a set delay, or stays silent
*/
`timescale 1ns/10ps

module tb_mem_model (
  input  logic           clk,
  input  logic           reset,
  input  logic           silent,
  input  logic [2:0]     delay,
  input  logic           memreq_val,
  input  pfb_pkg::addr_t memreq_addr,
  input  logic           memresp_rdy,
  output logic           memreq_rdy,
  output logic           memresp_val,
  output pfb_pkg::line_t memresp_data
);

  logic           req_taken;
  logic           resp_taken;
  logic           pending;
  int             wait_left;
  pfb_pkg::addr_t line_addr;

  // Word k of line A is A + 4k inverted
  function automatic pfb_pkg::line_t line_pattern(input pfb_pkg::addr_t addr);
    pfb_pkg::line_t line;
    int k;
    for (k = 0; k < 4; k++) begin
      line[k*32 +: 32] = ~(addr + 32'(4 * k));
    end
    return line;
  endfunction

  // Handshakes seen at the rising edge
  always @(posedge clk) begin
    req_taken  <= memreq_val && memreq_rdy;
    resp_taken <= memresp_val && memresp_rdy;
    if (memreq_val && memreq_rdy) begin
      line_addr <= memreq_addr;
    end
  end

  // Outputs change on the falling edge only
  initial begin
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    pending      = 1'b0;
    wait_left    = 0;
    forever begin
      @(negedge clk);
      memreq_rdy = !reset;
      if (reset || resp_taken) begin
        memresp_val = 1'b0;
        pending     = 1'b0;
      end else if (req_taken) begin
        pending   = !silent;
        wait_left = int'(delay);
      end else if (pending) begin
        if (wait_left == 0) begin
          memresp_val  = 1'b1;
          memresp_data = line_pattern(line_addr);
          pending      = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

endmodule

//--- tb/tb_prefetch_buffer.sv
/*
  Testbench for the prefetch buffer
  Shadow tag model predicts each response, assertions check it
*/
`timescale 1ns/10ps

module tb_prefetch_buffer;

  // 32 requests, each allowed a full refill timeout plus stalls
  localparam int NUM_REQS    = 32;
  localparam int REQ_CYCLES  = pfb_pkg::REFILL_TIMEOUT + 48;
  localparam int CYCLE_LIMIT = 10 + NUM_REQS * REQ_CYCLES;

  logic clk = 1'b0;
  logic reset;
  logic insecure;
  logic req_val;
  logic req_rdy;
  pfb_pkg::req_type_t req_type;
  pfb_pkg::addr_t req_addr;
  logic resp_val;
  logic resp_rdy;
  pfb_pkg::found_t resp_found;
  pfb_pkg::word_t resp_data;
  logic memreq_val;
  logic memreq_rdy;
  pfb_pkg::addr_t memreq_addr;
  logic memresp_val;
  logic memresp_rdy;
  pfb_pkg::line_t memresp_data;
  logic mem_silent;
  logic [2:0] mem_delay;

  logic [31:0] lfsr = 32'hd009;
  string test_name = "reset";
  int cycles = 0;
  int since_accept = 0;
  int memreq_count = 0;
  int wait_cycles = 0;

  // Shadow of valid, tag and LRU per set
  logic sh_valid [8][2] = '{default: 1'b0};
  pfb_pkg::tag_t sh_tag [8][2];
  logic sh_lru [8] = '{default: 1'b0};

  pfb_pkg::found_t exp_found = pfb_pkg::FOUND_MISS;
  pfb_pkg::word_t exp_data = '0;
  pfb_pkg::addr_t exp_memaddr = '0;
  logic exp_refill = 1'b0;
  int exp_latency = 0;
  int exp_wait = 0;

  always #50 clk = ~clk;

  prefetch_buffer i_prefetch_buffer (
    .clk (clk), .reset (reset), .insecure (insecure),
    .req_val (req_val), .req_rdy (req_rdy), .req_type (req_type), .req_addr (req_addr),
    .resp_val (resp_val), .resp_rdy (resp_rdy), .resp_found (resp_found),
    .resp_data (resp_data), .memreq_val (memreq_val), .memreq_rdy (memreq_rdy),
    .memreq_addr (memreq_addr), .memresp_val (memresp_val), .memresp_rdy (memresp_rdy),
    .memresp_data (memresp_data)
  );

  tb_mem_model i_mem_model (
    .clk (clk), .reset (reset), .silent (mem_silent), .delay (mem_delay),
    .memreq_val (memreq_val), .memreq_addr (memreq_addr), .memresp_rdy (memresp_rdy),
    .memreq_rdy (memreq_rdy), .memresp_val (memresp_val), .memresp_data (memresp_data)
  );

  // ------------------------------
  // Error reporting and random bits
  // ------------------------------
  task automatic value_mismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic run_error(input string what);
    $display("Error in %s: %s", test_name, what);
    $display("Something failed");
    $fatal(1);
  endtask

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Address layout is tag 31:7, set 6:4, word 3:2
  task automatic predict(input pfb_pkg::req_type_t kind, input pfb_pkg::addr_t addr,
                         input int mode);
    logic [2:0] idx;
    pfb_pkg::tag_t tag;
    int way;
    int w;
    logic victim;
    idx = addr[6:4];
    tag = addr[31:7];
    way = -1;
    for (w = 0; w < 2; w++) begin
      if (sh_valid[idx][w] && sh_tag[idx][w] == tag) begin
        way = w;
      end
    end
    exp_refill  = 1'b0;
    exp_data    = '0;
    exp_memaddr = {addr[31:4], 4'b0000};
    exp_latency = 2;
    if (way >= 0) begin
      exp_found = pfb_pkg::FOUND_HIT;
      if (kind == pfb_pkg::REQ_READ) begin
        exp_latency  = 3;
        exp_data     = ~(exp_memaddr + (32'(addr[3:2]) << 2));
        sh_lru[idx]  = (way == 0);
      end
    end else if (kind == pfb_pkg::REQ_READ) begin
      exp_found = pfb_pkg::FOUND_MISS;
    end else begin
      exp_refill = 1'b1;
      // Free way with way 0 first, else the LRU way
      victim = !sh_valid[idx][0] ? 1'b0 : (!sh_valid[idx][1] ? 1'b1 : sh_lru[idx]);
      if (mode == 0) begin
        exp_found              = pfb_pkg::FOUND_FILLED;
        sh_valid[idx][victim]  = 1'b1;
        sh_tag[idx][victim]    = tag;
        sh_lru[idx]            = !victim;
      end else begin
        exp_found = pfb_pkg::FOUND_ABORT;
      end
    end
  endtask

  // Mode 0 answers, 1 leaves memory silent, 2 raises insecure during the wait
  task automatic send_request(input pfb_pkg::req_type_t kind, input pfb_pkg::addr_t addr,
                              input int mode);
    logic [31:0] bits;
    logic done;
    predict(kind, addr, mode);
    take_bits(3, bits);
    mem_delay  = bits[2:0];
    mem_silent = (mode != 0);
    // Cycles spent with memresp_rdy high
    // Memory answers 2 + delay cycles in, a timeout ends the wait a cycle after expiry
    if (!exp_refill) begin
      exp_wait = 0;
    end else if (mode == 0) begin
      exp_wait = 2 + int'(mem_delay);
    end else if (mode == 1) begin
      exp_wait = pfb_pkg::REFILL_TIMEOUT + 1;
    end else begin
      exp_wait = 1;
    end
    req_val    = 1'b1;
    req_type   = kind;
    req_addr   = addr;
    while (!req_rdy) begin
      @(negedge clk);
    end
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      req_val = 1'b0;
      take_bits(2, bits);
      resp_rdy = |bits[1:0];
      insecure = (mode == 2) && memresp_rdy;
      done     = resp_val && resp_rdy;
    end
    @(negedge clk);
    resp_rdy = 1'b0;
    insecure = 1'b0;
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  always @(posedge clk) begin
    if (req_val && req_rdy) begin
      since_accept <= 1;
      memreq_count <= 0;
      wait_cycles  <= 0;
    end else begin
      since_accept <= since_accept + 1;
      if (memreq_val && memreq_rdy) begin
        memreq_count <= memreq_count + 1;
      end
      if (memresp_rdy) begin
        wait_cycles <= wait_cycles + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      run_error("run did not finish within the cycle limit");
    end
  end

  a_found: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> resp_found == exp_found)
    else value_mismatch("result code", 32'(exp_found), 32'($sampled(resp_found)));

  a_data: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> resp_data == exp_data)
    else value_mismatch("data", exp_data, $sampled(resp_data));

  a_latency: assert property (@(posedge clk) disable iff (reset)
    ($rose(resp_val) && !exp_refill) |-> since_accept == exp_latency)
    else value_mismatch("latency", 32'(exp_latency), 32'($sampled(since_accept)));

  a_memreq_count: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> memreq_count == (exp_refill ? 1 : 0))
    else value_mismatch("memreq count", 32'(exp_refill), 32'($sampled(memreq_count)));

  a_memreq_addr: assert property (@(posedge clk) disable iff (reset)
    (memreq_val && exp_refill) |-> memreq_addr == exp_memaddr)
    else value_mismatch("memreq address", exp_memaddr, $sampled(memreq_addr));

  a_memreq_needed: assert property (@(posedge clk) disable iff (reset)
    memreq_val |-> exp_refill)
    else run_error("memory request on a request that needs no refill");

  a_wait: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> wait_cycles == exp_wait)
    else value_mismatch("refill wait cycles", 32'(exp_wait), 32'($sampled(wait_cycles)));

  a_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val && $stable(resp_found) && $stable(resp_data))
    else run_error("response changed while the requester stalled");

  a_busy: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
    else run_error("request port ready while a response is pending");

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    logic [31:0] bits;
    pfb_pkg::addr_t addr;
    int i;
    reset      = 1'b1;
    insecure   = 1'b0;
    req_val    = 1'b0;
    req_type   = pfb_pkg::REQ_READ;
    req_addr   = '0;
    resp_rdy   = 1'b0;
    mem_silent = 1'b0;
    mem_delay  = '0;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    test_name = "read after reset";
    for (i = 0; i < 3; i++) begin
      take_bits(32, bits);
      send_request(pfb_pkg::REQ_READ, bits, 0);
    end

    test_name = "prefetch fill";
    send_request(pfb_pkg::REQ_PREFETCH, 32'h0001_0020, 0);
    for (i = 0; i < 4; i++) begin
      send_request(pfb_pkg::REQ_READ, 32'h0001_0020 + (32'(i) << 2), 0);
    end

    test_name = "prefetch present";
    send_request(pfb_pkg::REQ_PREFETCH, 32'h0001_0028, 0);

    // Three lines in set 5, the read makes the second one LRU
    test_name = "lru eviction";
    send_request(pfb_pkg::REQ_PREFETCH, 32'h0002_0050, 0);
    send_request(pfb_pkg::REQ_PREFETCH, 32'h0003_0050, 0);
    send_request(pfb_pkg::REQ_READ, 32'h0002_0054, 0);
    send_request(pfb_pkg::REQ_PREFETCH, 32'h0004_0050, 0);
    send_request(pfb_pkg::REQ_READ, 32'h0002_0050, 0);
    send_request(pfb_pkg::REQ_READ, 32'h0003_0050, 0);
    send_request(pfb_pkg::REQ_READ, 32'h0004_0050, 0);

    test_name = "insecure abort";
    send_request(pfb_pkg::REQ_PREFETCH, 32'h0005_0060, 2);
    send_request(pfb_pkg::REQ_READ, 32'h0005_0060, 0);
    test_name = "timeout abort";
    send_request(pfb_pkg::REQ_PREFETCH, 32'h0005_0060, 1);
    send_request(pfb_pkg::REQ_READ, 32'h0005_0060, 0);

    // Four tags over sets 0 and 1 force evictions
    test_name = "random stalls";
    for (i = 0; i < 12; i++) begin
      take_bits(6, bits);
      addr = 32'h0006_0000 + (32'(bits[4:3]) << 7) + (32'(bits[2]) << 4)
           + (32'(bits[1:0]) << 2);
      send_request(pfb_pkg::req_type_t'(bits[5]), addr, 0);
    end

    $display("Everything OK");
    $finish;
  end

endmodule

//--- filelist.f
logic/pfb_pkg.sv
logic/pfb_regfile.sv
logic/pfb_tag_array.sv
logic/pfb_data_path.sv
logic/pfb_refill_timer.sv
logic/pfb_ctrl.sv
logic/prefetch_buffer.sv
tb/tb_mem_model.sv
tb/tb_prefetch_buffer.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_prefetch_buffer
FILELIST := filelist.f
BUILD    := obj_dir
LOG      := sim.log
PASS     := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
